// File: common/fp_add_settings.svh
`ifndef FP_ADD_SETTINGS_SVH
`define FP_ADD_SETTINGS_SVH

////////////////////
// Number format.

`define FP_EXP_WIDTH     8     // Biased exponent bits.
`define FP_FRAC_WIDTH    23    // Stored fraction bits.

// Extra low bits kept through alignment. The last one acts as sticky.
`define FP_GUARD_BITS    3

////////////////////
// Configuration defaults.

`define FP_DEFAULT_ROUND 1'b1  // Nearest-even.

`endif

// File: common/fp_add_pkg.sv
`default_nettype none

package fp_add_pkg;

`include "fp_add_settings.svh"

    // Hidden bit, fraction and guard bits.
    localparam int EXT_SIG_WIDTH = `FP_FRAC_WIDTH + 1 + `FP_GUARD_BITS;

    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } fp_op_e;

    typedef enum logic {
        ROUND_CHOP         = 1'b0,
        ROUND_NEAREST_EVEN = 1'b1
    } round_mode_e;

    typedef struct packed {
        logic                        valid;
        logic                        sign;
        logic [`FP_EXP_WIDTH-1:0]    exponent;
        logic [`FP_FRAC_WIDTH-1:0]   fraction;
    } fp_operand_t;

    typedef struct packed {
        logic                        sign;
        logic [`FP_EXP_WIDTH-1:0]    exponent;
        logic [`FP_FRAC_WIDTH-1:0]   fraction;
    } fp_result_t;

    typedef struct packed {
        logic                        sign;       // Sign of the larger magnitude.
        logic                        subtract;   // Effective operation after signs.
        logic [`FP_EXP_WIDTH-1:0]    exponent;   // Common exponent.
        logic [EXT_SIG_WIDTH-1:0]    sig_large;
        logic [EXT_SIG_WIDTH-1:0]    sig_small;  // Already shifted.
    } fp_aligned_t;

endpackage

`default_nettype wire

// File: fp_adder/operand_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_add_settings.svh"

module operand_align
(
    input  fp_add_pkg::fp_operand_t operand_0,
    input  fp_add_pkg::fp_operand_t operand_1,
    input  fp_add_pkg::fp_op_e      operation_mode,
    output fp_add_pkg::fp_aligned_t aligned
);
    import fp_add_pkg::*;

    localparam int EXP_W = `FP_EXP_WIDTH;
    localparam int GRD_W = `FP_GUARD_BITS;

    logic [EXT_SIG_WIDTH-1:0] sig_0;
    logic [EXT_SIG_WIDTH-1:0] sig_1;
    logic [EXT_SIG_WIDTH-1:0] sig_small;
    logic [EXT_SIG_WIDTH-1:0] shifted;
    logic [EXT_SIG_WIDTH-1:0] lost_mask;
    logic [EXP_W-1:0]         exp_small;
    logic [EXP_W-1:0]         exp_diff;
    logic                     sign_1_eff;
    logic                     swap;

    // Exponent zero flushes to zero.
    assign sig_0 = (operand_0.exponent == '0) ? '0 :
                   {1'b1, operand_0.fraction, {GRD_W{1'b0}}};
    assign sig_1 = (operand_1.exponent == '0) ? '0 :
                   {1'b1, operand_1.fraction, {GRD_W{1'b0}}};

    assign sign_1_eff = operand_1.sign ^ (operation_mode == OP_SUB);
    assign swap       = {operand_1.exponent, sig_1} > {operand_0.exponent, sig_0};

    assign exp_small = swap ? operand_0.exponent : operand_1.exponent;
    assign sig_small = swap ? sig_0 : sig_1;

    always_comb
    begin
        aligned.sign      = swap ? sign_1_eff : operand_0.sign;
        aligned.subtract  = operand_0.sign ^ sign_1_eff;
        aligned.exponent  = swap ? operand_1.exponent : operand_0.exponent;
        aligned.sig_large = swap ? sig_1 : sig_0;

        exp_diff  = aligned.exponent - exp_small;
        shifted   = sig_small >> exp_diff;
        lost_mask = ~({EXT_SIG_WIDTH{1'b1}} << exp_diff);   // Bits pushed out below.

        // Lost bits collapse into the sticky position.
        aligned.sig_small = {shifted[EXT_SIG_WIDTH-1:1],
                             shifted[0] | (|(sig_small & lost_mask))};
    end

endmodule

`default_nettype wire

// File: fp_adder/mantissa_normalize.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_add_settings.svh"

module mantissa_normalize
(
    input  logic [`FP_EXP_WIDTH-1:0]             raw_exponent,
    input  logic [fp_add_pkg::EXT_SIG_WIDTH:0]   raw_sum,
    output logic [`FP_EXP_WIDTH-1:0]             norm_exponent,
    output logic [fp_add_pkg::EXT_SIG_WIDTH-1:0] norm_significand,
    output logic                                 is_zero
);
    import fp_add_pkg::*;

    localparam int EXP_W = `FP_EXP_WIDTH;
    localparam int LZ_W  = $clog2(EXT_SIG_WIDTH);

    logic [LZ_W-1:0] lead_zeros;
    logic            carry;

    assign carry = raw_sum[EXT_SIG_WIDTH];

    always_comb
    begin
        lead_zeros = '0;
        for (int i = 0; i < EXT_SIG_WIDTH; i++)
        begin
            if (raw_sum[i])
            begin
                lead_zeros = LZ_W'(EXT_SIG_WIDTH - 1 - i);  // Highest set bit wins.
            end
        end
    end

    always_comb
    begin
        if (carry)
        begin
            norm_significand = {raw_sum[EXT_SIG_WIDTH:2], raw_sum[1] | raw_sum[0]};
            norm_exponent    = raw_exponent + 1'b1;
            is_zero          = 1'b0;
        end
        else
        begin
            norm_significand = raw_sum[EXT_SIG_WIDTH-1:0] << lead_zeros;
            norm_exponent    = raw_exponent - EXP_W'(lead_zeros);
            // Cancellation or underflow.
            is_zero = (raw_sum == '0) ||
                      ({1'b0, raw_exponent} <= (EXP_W + 1)'(lead_zeros));
        end
    end

endmodule

`default_nettype wire

// File: fp_adder/number_round.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_add_settings.svh"

module number_round
(
    input  fp_add_pkg::round_mode_e                round_mode,
    input  logic [`FP_EXP_WIDTH-1:0]             norm_exponent,
    input  logic [fp_add_pkg::EXT_SIG_WIDTH-1:0] norm_significand,
    output logic [`FP_EXP_WIDTH-1:0]             rounded_exponent,
    output logic [`FP_FRAC_WIDTH-1:0]            rounded_fraction,
    output logic                                 is_rounded
);
    import fp_add_pkg::*;

    localparam int EXP_W  = `FP_EXP_WIDTH;
    localparam int FRAC_W = `FP_FRAC_WIDTH;
    localparam int GRD_W  = `FP_GUARD_BITS;

    logic [FRAC_W:0]   kept;            // Hidden bit and fraction.
    logic              guard_bit;
    logic              tail_bits;
    logic              increment;
    logic [FRAC_W+1:0] incremented;
    logic              round_carry;

    assign kept      = norm_significand[EXT_SIG_WIDTH-1:GRD_W];
    assign guard_bit = norm_significand[GRD_W-1];
    assign tail_bits = |norm_significand[GRD_W-2:0];

    // Ties go to the even neighbour.
    assign increment = (round_mode == ROUND_NEAREST_EVEN) && guard_bit &&
                       (tail_bits || kept[0]);

    assign incremented = {1'b0, kept} + {{(FRAC_W + 1){1'b0}}, increment};
    assign round_carry = incremented[FRAC_W+1];

    assign rounded_exponent = norm_exponent + {{(EXP_W - 1){1'b0}}, round_carry};
    assign rounded_fraction = round_carry ? incremented[FRAC_W:1] : incremented[FRAC_W-1:0];
    assign is_rounded       = guard_bit | tail_bits;

endmodule

`default_nettype wire

// File: fp_adder/float_point_adder.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_add_settings.svh"

module float_point_adder
(
    input  logic                    clk_in,
    input  logic                    reset_in,
    input  fp_add_pkg::fp_operand_t operand_0,
    input  fp_add_pkg::fp_operand_t operand_1,
    input  fp_add_pkg::fp_op_e      operation_mode,
    input  fp_add_pkg::round_mode_e round_mode,
    input  logic                    issue_ack_in,
    output logic                    issue_ack_out,
    output logic                    product_valid,
    output logic                    result_strobe,
    output logic                    result_inexact,
    output fp_add_pkg::fp_result_t  product
);
    import fp_add_pkg::*;

    typedef enum logic [1:0] {
        STATE_WAIT_INPUT = 2'd0,
        STATE_PRE_SHIFT  = 2'd1,
        STATE_COMPUTE    = 2'd2,
        STATE_POST_SHIFT = 2'd3
    } ctrl_state_e;

    ctrl_state_e                ctrl_state;
    logic                       norm_ready;     // Normalized value waits for rounding.
    logic                       capture;

    fp_operand_t                operand_0_buffer;
    fp_operand_t                operand_1_buffer;
    fp_op_e                     operation_buffer;

    fp_aligned_t                aligned;
    fp_aligned_t                aligned_reg;    // Sign and exponent live here until done.
    logic [EXT_SIG_WIDTH:0]     sum_reg;

    logic [`FP_EXP_WIDTH-1:0]   norm_exponent;
    logic [EXT_SIG_WIDTH-1:0]   norm_significand;
    logic                       norm_zero;
    logic [`FP_EXP_WIDTH-1:0]   norm_exponent_reg;
    logic [EXT_SIG_WIDTH-1:0]   norm_significand_reg;
    logic                       norm_zero_reg;

    logic [`FP_EXP_WIDTH-1:0]   rounded_exponent;
    logic [`FP_FRAC_WIDTH-1:0]  rounded_fraction;
    logic                       is_rounded;

    assign capture = (ctrl_state == STATE_WAIT_INPUT) && operand_0.valid && operand_1.valid;

    ////////////////////
    // Control.

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            ctrl_state    <= STATE_WAIT_INPUT;
            issue_ack_out <= 1'b0;
            product_valid <= 1'b0;
            result_strobe <= 1'b0;
            norm_ready    <= 1'b0;
        end
        else
        begin
            issue_ack_out <= capture;   // One cycle, state has moved on.
            result_strobe <= 1'b0;
            case (ctrl_state)
                STATE_WAIT_INPUT:
                begin
                    if (capture)
                    begin
                        ctrl_state <= STATE_PRE_SHIFT;
                    end
                end
                STATE_PRE_SHIFT:
                begin
                    ctrl_state <= STATE_COMPUTE;
                end
                STATE_COMPUTE:
                begin
                    ctrl_state <= STATE_POST_SHIFT;
                end
                STATE_POST_SHIFT:
                begin
                    if (!norm_ready)
                    begin
                        norm_ready <= 1'b1;
                    end
                    else if (!product_valid)
                    begin
                        product_valid <= 1'b1;
                        result_strobe <= 1'b1;
                    end
                    else if (issue_ack_in)
                    begin
                        product_valid <= 1'b0;
                        norm_ready    <= 1'b0;
                        ctrl_state    <= STATE_WAIT_INPUT;
                    end
                end
                default:
                begin
                    ctrl_state <= STATE_WAIT_INPUT;
                end
            endcase
        end
    end

    ////////////////////
    // Datapath.

    always_ff @(posedge clk_in)
    begin
        if (capture)
        begin
            operand_0_buffer <= operand_0;
            operand_1_buffer <= operand_1;
            operation_buffer <= operation_mode;
        end
        if (ctrl_state == STATE_PRE_SHIFT)
        begin
            aligned_reg <= aligned;
        end
        if (ctrl_state == STATE_COMPUTE)
        begin
            // Larger magnitude always on the left.
            if (aligned_reg.subtract)
            begin
                sum_reg <= {1'b0, aligned_reg.sig_large} - {1'b0, aligned_reg.sig_small};
            end
            else
            begin
                sum_reg <= {1'b0, aligned_reg.sig_large} + {1'b0, aligned_reg.sig_small};
            end
        end
        if ((ctrl_state == STATE_POST_SHIFT) && !norm_ready)
        begin
            norm_exponent_reg    <= norm_exponent;
            norm_significand_reg <= norm_significand;
            norm_zero_reg        <= norm_zero;
        end
        if ((ctrl_state == STATE_POST_SHIFT) && norm_ready && !product_valid)
        begin
            product.sign     <= norm_zero_reg ? 1'b0 : aligned_reg.sign;   // Zero is +0.
            product.exponent <= norm_zero_reg ? '0 : rounded_exponent;
            product.fraction <= norm_zero_reg ? '0 : rounded_fraction;
            result_inexact   <= is_rounded & ~norm_zero_reg;
        end
    end

    operand_align operand_align_inst
    (
        .operand_0      (operand_0_buffer),
        .operand_1      (operand_1_buffer),
        .operation_mode (operation_buffer),
        .aligned        (aligned)
    );

    mantissa_normalize mantissa_normalize_inst
    (
        .raw_exponent     (aligned_reg.exponent),
        .raw_sum          (sum_reg),
        .norm_exponent    (norm_exponent),
        .norm_significand (norm_significand),
        .is_zero          (norm_zero)
    );

    number_round number_round_inst
    (
        .round_mode       (round_mode),
        .norm_exponent    (norm_exponent_reg),
        .norm_significand (norm_significand_reg),
        .rounded_exponent (rounded_exponent),
        .rounded_fraction (rounded_fraction),
        .is_rounded       (is_rounded)
    );

endmodule

`default_nettype wire

// File: source/fp_round_config.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_add_settings.svh"

module fp_round_config
(
    input  logic                    clk_in,
    input  logic                    reset_in,
    input  logic                    cfg_write,
    input  fp_add_pkg::round_mode_e cfg_round_mode,
    input  logic                    result_strobe,
    input  logic                    result_inexact,
    output fp_add_pkg::round_mode_e round_mode,
    output logic                    inexact_flag
);
    import fp_add_pkg::*;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            round_mode   <= round_mode_e'(`FP_DEFAULT_ROUND);
            inexact_flag <= 1'b0;
        end
        else if (cfg_write)
        begin
            round_mode   <= cfg_round_mode;
            inexact_flag <= 1'b0;   // Write clears status.
        end
        else if (result_strobe && result_inexact)
        begin
            inexact_flag <= 1'b1;   // Sticky.
        end
    end

endmodule

`default_nettype wire

// File: source/fp_add_top.sv
`timescale 1ns/1ps
`default_nettype none

module fp_add_top
(
    input  logic                    clk_in,
    input  logic                    reset_in,
    input  fp_add_pkg::fp_operand_t operand_0,
    input  fp_add_pkg::fp_operand_t operand_1,
    input  fp_add_pkg::fp_op_e      operation_mode,
    input  logic                    issue_ack_in,
    input  logic                    cfg_write,
    input  fp_add_pkg::round_mode_e cfg_round_mode,
    output logic                    issue_ack_out,
    output logic                    product_valid,
    output fp_add_pkg::fp_result_t  product,
    output fp_add_pkg::round_mode_e round_mode,
    output logic                    inexact_flag
);
    logic result_strobe;
    logic result_inexact;

    fp_round_config fp_round_config_inst
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .cfg_write      (cfg_write),
        .cfg_round_mode (cfg_round_mode),
        .result_strobe  (result_strobe),
        .result_inexact (result_inexact),
        .round_mode     (round_mode),
        .inexact_flag   (inexact_flag)
    );

    float_point_adder float_point_adder_inst
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .operand_0      (operand_0),
        .operand_1      (operand_1),
        .operation_mode (operation_mode),
        .round_mode     (round_mode),
        .issue_ack_in   (issue_ack_in),
        .issue_ack_out  (issue_ack_out),
        .product_valid  (product_valid),
        .result_strobe  (result_strobe),
        .result_inexact (result_inexact),
        .product        (product)
    );

endmodule

`default_nettype wire

// File: tests/fp_add_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module fp_add_assertions
(
    input logic                   clk_in,
    input logic                   reset_in,
    input logic                   issue_ack_out,
    input logic                   issue_ack_in,
    input logic                   product_valid,
    input fp_add_pkg::fp_result_t product
);

    int failure_count = 0;   // Failed assertions so far.

    ////////////////////
    // Handshake rules.

    ack_single_cycle: assert property (@(posedge clk_in) disable iff (reset_in)
        issue_ack_out |=> !issue_ack_out)
        else
        begin
            failure_count++;
            $error("issue_ack_out high for two cycles");
        end

    // Result waits unchanged for its acknowledge.
    product_held: assert property (@(posedge clk_in) disable iff (reset_in)
        (product_valid && !issue_ack_in) |=> (product_valid && $stable(product)))
        else
        begin
            failure_count++;
            $error("product changed before acknowledge");
        end

    valid_drops: assert property (@(posedge clk_in) disable iff (reset_in)
        (product_valid && issue_ack_in) |=> !product_valid)
        else
        begin
            failure_count++;
            $error("product_valid still high after acknowledge");
        end

endmodule

`default_nettype wire

// File: tests/fp_add_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_add_settings.svh"

module fp_add_tb;
    import fp_add_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int TABLE_COUNT  = 18;
    localparam int RANDOM_COUNT = 40;
    localparam int WATCHDOG_NS  = (TABLE_COUNT + RANDOM_COUNT) * 20 * CLK_PERIOD;

    typedef struct packed {
        logic        write_cfg;    // Write the round mode first.
        logic        op;
        logic        mode;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        logic        inexact;      // Sticky flag after this entry.
        logic        check_flag;
    } test_vec_t;

    logic        clk_in;
    logic        reset_in;
    fp_operand_t operand_0;
    fp_operand_t operand_1;
    fp_op_e      operation_mode;
    logic        issue_ack_in;
    logic        cfg_write;
    round_mode_e cfg_round_mode;
    logic        issue_ack_out;
    logic        product_valid;
    fp_result_t  product;
    round_mode_e round_mode;
    logic        inexact_flag;

    test_vec_t   vectors[$];
    logic [15:0] lfsr_state;
    int          error_count;
    int          check_count;
    int          ack_pulses;

    fp_add_top fp_add_top_inst
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .operand_0      (operand_0),
        .operand_1      (operand_1),
        .operation_mode (operation_mode),
        .issue_ack_in   (issue_ack_in),
        .cfg_write      (cfg_write),
        .cfg_round_mode (cfg_round_mode),
        .issue_ack_out  (issue_ack_out),
        .product_valid  (product_valid),
        .product        (product),
        .round_mode     (round_mode),
        .inexact_flag   (inexact_flag)
    );

    bind float_point_adder fp_add_assertions fp_add_assertions_inst
    (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .issue_ack_out (issue_ack_out),
        .issue_ack_in  (issue_ack_in),
        .product_valid (product_valid),
        .product       (product)
    );

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    always @(negedge clk_in)
    begin
        if (!reset_in && issue_ack_out)
        begin
            ack_pulses++;
        end
    end

    ////////////////////
    // Helpers.

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic real single_to_real(input logic [31:0] bits);
        logic [10:0] dexp;
        if (bits[30:23] == 8'd0)
        begin
            return 0.0;
        end
        dexp = {3'b000, bits[30:23]} + 11'd896;   // Rebias 127 to 1023.
        return $bitstoreal({bits[31], dexp, bits[22:0], 29'd0});
    endfunction

    // Nearest-even conversion of a double to single precision.
    function automatic logic [31:0] real_to_single(input real value);
        logic [63:0] d;
        logic [24:0] sig;
        logic        guard;
        logic        sticky;
        int          exp32;
        d = $realtobits(value);
        if (d[62:0] == '0)
        begin
            return 32'h0;
        end
        sig    = {2'b01, d[51:29]};
        guard  = d[28];
        sticky = |d[27:0];
        if (guard && (sticky || sig[0]))
        begin
            sig = sig + 25'd1;
        end
        exp32 = d[62:52];
        exp32 = exp32 - 896;
        if (sig[24])
        begin
            exp32++;
            sig = sig >> 1;
        end
        return {d[63], exp32[7:0], sig[22:0]};
    endfunction

    function automatic test_vec_t table_entry(input logic write_cfg, input logic op,
                                              input logic mode, input logic [31:0] a,
                                              input logic [31:0] b, input logic [31:0] expected,
                                              input logic inexact, input logic check_flag);
        return {write_cfg, op, mode, a, b, expected, inexact, check_flag};
    endfunction

    task automatic random_operand(output logic [31:0] value);
        logic [31:0] sign;
        logic [31:0] exponent;
        logic [31:0] fraction;
        draw_bits(1, sign);
        draw_bits(7, exponent);
        draw_bits(23, fraction);
        value = {sign[0], 8'(64 + (exponent % 127)), fraction[22:0]};   // 64 to 190.
    endtask

    task automatic add_random_vector(input logic first);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] op;
        real         result;
        random_operand(a);
        random_operand(b);
        draw_bits(1, op);
        if (op[0])
        begin
            result = single_to_real(a) - single_to_real(b);
        end
        else
        begin
            result = single_to_real(a) + single_to_real(b);
        end
        vectors.push_back(table_entry(first, op[0], 1'b1, a, b, real_to_single(result),
                                      1'b0, 1'b0));
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected, input int idx);
        check_count++;
        assert (got === expected)
        else
        begin
            $display("FAIL %0t: test %0d %s is %h, expected %h", $time, idx, what, got,
                     expected);
            error_count++;
        end
    endtask

    task automatic run_vector(input int idx, input test_vec_t v);
        logic [31:0] stall;
        fp_result_t  held;
        int          errors_before;
        int          pulses_before;
        errors_before = error_count;
        if (v.write_cfg)
        begin
            cfg_write      = 1'b1;
            cfg_round_mode = round_mode_e'(v.mode);
            @(posedge clk_in);
            #DRIVE_DELAY;
            cfg_write = 1'b0;
        end
        check_value("round mode", 32'(round_mode), 32'(v.mode), idx);
        pulses_before  = ack_pulses;
        operand_0      = {1'b1, v.a};
        operand_1      = {1'b1, v.b};
        operation_mode = fp_op_e'(v.op);
        while (!product_valid)
        begin
            @(posedge clk_in);
            #DRIVE_DELAY;
        end
        // Valids stay high through the stall.
        draw_bits(3, stall);
        held = product;
        repeat (stall + 1)
        begin
            @(posedge clk_in);
            #DRIVE_DELAY;
            check_value("held product", product, held, idx);
            check_value("product valid", 32'(product_valid), 32'd1, idx);
        end
        check_value("product", product, v.expected, idx);
        if (v.check_flag)
        begin
            check_value("inexact flag", 32'(inexact_flag), 32'(v.inexact), idx);
        end
        issue_ack_in    = 1'b1;
        operand_0.valid = 1'b0;
        operand_1.valid = 1'b0;
        @(posedge clk_in);
        #DRIVE_DELAY;
        issue_ack_in = 1'b0;
        check_value("product valid after ack", 32'(product_valid), 32'd0, idx);
        check_value("issue ack pulses", ack_pulses - pulses_before, 32'd1, idx);
        $display("Test %0d %s: %h %s %h gives %h after %0d stall cycles", idx,
                 (error_count == errors_before) ? "ok" : "wrong", v.a, v.op ? "-" : "+",
                 v.b, held, stall + 1);
    endtask

    ////////////////////
    // Main sequence.

    initial
    begin
        clk_in         = 1'b0;
        reset_in       = 1'b1;
        operand_0      = '0;
        operand_1      = '0;
        operation_mode = OP_ADD;
        issue_ack_in   = 1'b0;
        cfg_write      = 1'b0;
        cfg_round_mode = ROUND_NEAREST_EVEN;
        error_count    = 0;
        check_count    = 0;
        ack_pulses     = 0;
        lfsr_state     = 16'd12860;

        // Write, op, mode, operand 0, operand 1, result, inexact flag, flag checked.
        vectors.push_back(table_entry(1, OP_ADD, ROUND_NEAREST_EVEN, 32'h3f800000,
                                      32'h3f800000, 32'h40000000, 0, 1));
        vectors.push_back(table_entry(0, OP_ADD, ROUND_NEAREST_EVEN, 32'h3fc00000,
                                      32'h40100000, 32'h40700000, 0, 1));
        vectors.push_back(table_entry(0, OP_ADD, ROUND_NEAREST_EVEN, 32'h3f800000,
                                      32'h33800000, 32'h3f800000, 1, 1));   // Tie to even.
        vectors.push_back(table_entry(0, OP_ADD, ROUND_NEAREST_EVEN, 32'h3f800000,
                                      32'h34400000, 32'h3f800002, 1, 1));
        vectors.push_back(table_entry(0, OP_ADD, ROUND_NEAREST_EVEN, 32'h40000000,
                                      32'h40000000, 32'h40800000, 1, 1));
        vectors.push_back(table_entry(1, OP_SUB, ROUND_CHOP, 32'h40800000,
                                      32'h3f800000, 32'h40400000, 0, 1));
        vectors.push_back(table_entry(0, OP_ADD, ROUND_CHOP, 32'h3f800000,
                                      32'h34400000, 32'h3f800001, 1, 1));
        vectors.push_back(table_entry(0, OP_ADD, ROUND_CHOP, 32'h3f800000,
                                      32'h33c00000, 32'h3f800000, 1, 1));
        vectors.push_back(table_entry(0, OP_ADD, ROUND_CHOP, 32'hbf800000,
                                      32'hb4400000, 32'hbf800001, 1, 1));
        vectors.push_back(table_entry(1, OP_ADD, ROUND_NEAREST_EVEN, 32'h3f800000,
                                      32'h33c00000, 32'h3f800001, 1, 1));
        vectors.push_back(table_entry(1, OP_SUB, ROUND_NEAREST_EVEN, 32'h3f800000,
                                      32'h3f800000, 32'h00000000, 0, 1));
        vectors.push_back(table_entry(0, OP_ADD, ROUND_NEAREST_EVEN, 32'h40400000,
                                      32'hc0400000, 32'h00000000, 0, 1));
        vectors.push_back(table_entry(0, OP_SUB, ROUND_NEAREST_EVEN, 32'h40000000,
                                      32'h40400000, 32'hbf800000, 0, 1));
        vectors.push_back(table_entry(0, OP_SUB, ROUND_NEAREST_EVEN, 32'h3f800001,
                                      32'h3f800000, 32'h34000000, 0, 1));   // Shift by 23.
        vectors.push_back(table_entry(0, OP_ADD, ROUND_NEAREST_EVEN, 32'h3f800000,
                                      32'hbe800000, 32'h3f400000, 0, 1));
        vectors.push_back(table_entry(0, OP_SUB, ROUND_NEAREST_EVEN, 32'h3f800000,
                                      32'h33000000, 32'h3f800000, 1, 1));
        vectors.push_back(table_entry(1, OP_SUB, ROUND_CHOP, 32'h3f800000,
                                      32'h33000000, 32'h3f7fffff, 1, 1));
        vectors.push_back(table_entry(0, OP_SUB, ROUND_CHOP, 32'h40400000,
                                      32'hc0400000, 32'h40c00000, 1, 1));
        for (int i = 0; i < RANDOM_COUNT; i++)
        begin
            add_random_vector(i == 0);
        end

        repeat (2) @(posedge clk_in);
        #DRIVE_DELAY;
        reset_in = 1'b0;
        check_value("reset issue ack", 32'(issue_ack_out), 32'd0, 0);
        check_value("reset product valid", 32'(product_valid), 32'd0, 0);
        check_value("reset inexact flag", 32'(inexact_flag), 32'd0, 0);
        check_value("reset round mode", 32'(round_mode), 32'(`FP_DEFAULT_ROUND), 0);

        foreach (vectors[i])
        begin
            run_vector(i, vectors[i]);
        end

        // Handshake assertions count as errors too.
        error_count += fp_add_top_inst.float_point_adder_inst.fp_add_assertions_inst.failure_count;

        $display("Tests %0d, checks %0d, errors %0d", vectors.size(), check_count,
                 error_count);
        if (error_count == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("The run timed out after %0t, the adder never finished its work", $time);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/fp_add_pkg.sv
fp_adder/operand_align.sv
fp_adder/mantissa_normalize.sv
fp_adder/number_round.sv
fp_adder/float_point_adder.sv
source/fp_round_config.sv
source/fp_add_top.sv
tests/fp_add_assertions.sv
tests/fp_add_tb.sv

// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -Wno-fatal
TOP       := fp_add_tb
FILE_LIST := build.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILE_LIST)) common/fp_add_settings.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Checks failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
